//--- common/mem_pkg.sv
package mem_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = 4;

    // Address map, same regions as the SoC crossbar
    localparam logic [ADDR_W-1:0] ROM_BASE  = 32'h0001_0000;
    localparam logic [ADDR_W-1:0] ROM_LEN   = 32'h0001_0000;
    localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h8000_0000;
    localparam logic [ADDR_W-1:0] SRAM_LEN  = 32'h1000_0000;

    localparam int ROM_WORDS  = 16;
    localparam int SRAM_WORDS = 1024;

    localparam int OFF_W      = $clog2(BE_W);
    localparam int ROM_IDX_W  = $clog2(ROM_WORDS);
    localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);

    typedef enum logic [1:0] {
        REGION_ROM,
        REGION_SRAM,
        REGION_NONE
    } region_e;

    // Upper address bits are ignored, so each region wraps on its depth
    typedef union packed {
        struct packed {
            logic [ADDR_W-ROM_IDX_W-OFF_W-1:0] pad;
            logic [ROM_IDX_W-1:0]              idx;
            logic [OFF_W-1:0]                  off;
        } rom_view;
        struct packed {
            logic [ADDR_W-SRAM_IDX_W-OFF_W-1:0] pad;
            logic [SRAM_IDX_W-1:0]              idx;
            logic [OFF_W-1:0]                   off;
        } sram_view;
    } mem_addr_u;

endpackage

//--- common/mem_req_if.sv
`timescale 1ns/10ps

interface mem_req_if;

    logic                         valid;
    logic                         ready;
    mem_pkg::region_e             region;
    mem_pkg::mem_addr_u           addr;
    logic                         we;
    logic [mem_pkg::BE_W-1:0]     be;
    logic [mem_pkg::DATA_W-1:0]   wdata;

    modport src (
        output valid, region, addr, we, be, wdata,
        input  ready
    );

    modport dst (
        input  valid, region, addr, we, be, wdata,
        output ready
    );

endinterface

//--- src/bus_front.sv
`timescale 1ns/10ps

module bus_front (
    input  logic                       req_i,
    input  logic [mem_pkg::ADDR_W-1:0] addr_i,
    input  logic                       we_i,
    input  logic [mem_pkg::BE_W-1:0]   be_i,
    input  logic [mem_pkg::DATA_W-1:0] wdata_i,
    output logic                       gnt_o,
    mem_req_if.src                     front_q
);

    logic rom_hit;
    logic sram_hit;

    assign rom_hit  = (addr_i >= mem_pkg::ROM_BASE) &&
                      (addr_i <  mem_pkg::ROM_BASE + mem_pkg::ROM_LEN);
    assign sram_hit = (addr_i >= mem_pkg::SRAM_BASE) &&
                      (addr_i <  mem_pkg::SRAM_BASE + mem_pkg::SRAM_LEN);

    always_comb
    begin
        if (rom_hit)
        begin
            front_q.region = mem_pkg::REGION_ROM;
        end
        else if (sram_hit)
        begin
            front_q.region = mem_pkg::REGION_SRAM;
        end
        else
        begin
            front_q.region = mem_pkg::REGION_NONE;
        end
    end

    // A request is granted on the edge where the queue takes it
    assign front_q.valid = req_i;
    assign gnt_o         = req_i & front_q.ready;

    assign front_q.addr  = addr_i;
    assign front_q.we    = we_i;
    assign front_q.be    = be_i;
    assign front_q.wdata = wdata_i;

endmodule

//--- src/req_fifo.sv
`timescale 1ns/10ps

module req_fifo #(
    parameter int DEPTH = 2
) (
    input  logic   clk_i,
    input  logic   rst_ni,
    mem_req_if.dst in_q,
    mem_req_if.src out_q
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    mem_pkg::region_e           region_q [DEPTH];
    mem_pkg::mem_addr_u         addr_q   [DEPTH];
    logic                       we_q     [DEPTH];
    logic [mem_pkg::BE_W-1:0]   be_q     [DEPTH];
    logic [mem_pkg::DATA_W-1:0] wdata_q  [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_q.ready  = (count != CNT_W'(DEPTH));
    assign out_q.valid = (count != '0);
    assign push        = in_q.valid & in_q.ready;
    assign pop         = out_q.valid & out_q.ready;

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop)
            begin
                count <= count + 1'b1;
            end
            else if (pop && !push)
            begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (push)
        begin
            region_q[wr_ptr] <= in_q.region;
            addr_q[wr_ptr]   <= in_q.addr;
            we_q[wr_ptr]     <= in_q.we;
            be_q[wr_ptr]     <= in_q.be;
            wdata_q[wr_ptr]  <= in_q.wdata;
        end
    end

    // Head of the queue is presented straight from storage
    assign out_q.region = region_q[rd_ptr];
    assign out_q.addr   = addr_q[rd_ptr];
    assign out_q.we     = we_q[rd_ptr];
    assign out_q.be     = be_q[rd_ptr];
    assign out_q.wdata  = wdata_q[rd_ptr];

endmodule

//--- src/heartbeat.sv
`timescale 1ns/10ps

module heartbeat #(
    parameter int DIV = 100_000_000
) (
    input  logic clk_i,
    input  logic rst_ni,
    output logic led_o
);

    localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            led_o <= 1'b0;
            cnt   <= '0;
        end
        else if (cnt == CNT_W'(DIV - 1))
        begin
            led_o <= ~led_o;
            cnt   <= '0;
        end
        else
        begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

//--- mem_backend/mem_backend.sv
`timescale 1ns/10ps

module mem_backend (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    mem_req_if.dst                     req_q,
    output logic                       rvalid_o,
    output logic [mem_pkg::DATA_W-1:0] rdata_o,
    output logic                       err_o
);

    logic [mem_pkg::DATA_W-1:0] rom  [mem_pkg::ROM_WORDS];
    logic [mem_pkg::DATA_W-1:0] sram [mem_pkg::SRAM_WORDS];

    logic                       pop;
    logic                       sram_wr;
    logic                       resp_err;
    logic [mem_pkg::DATA_W-1:0] resp_data;

    initial
    begin
        $readmemh("mem_backend/boot_rom.hex", rom);
        for (int i = 0; i < mem_pkg::SRAM_WORDS; i++)
        begin
            sram[i] = '0;
        end
    end

    // Back end never stalls, one item leaves the queue per cycle
    assign req_q.ready = 1'b1;
    assign pop         = req_q.valid & req_q.ready;
    assign sram_wr     = pop && req_q.we && (req_q.region == mem_pkg::REGION_SRAM);

    always_comb
    begin
        resp_err  = 1'b0;
        resp_data = '0;
        case (req_q.region)
            mem_pkg::REGION_ROM:
            begin
                // ROM is read only
                if (req_q.we)
                begin
                    resp_err = 1'b1;
                end
                else
                begin
                    resp_data = rom[req_q.addr.rom_view.idx];
                end
            end
            mem_pkg::REGION_SRAM:
            begin
                if (!req_q.we)
                begin
                    resp_data = sram[req_q.addr.sram_view.idx];
                end
            end
            default:
            begin
                resp_err = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (sram_wr)
        begin
            for (int b = 0; b < mem_pkg::BE_W; b++)
            begin
                if (req_q.be[b])
                begin
                    sram[req_q.addr.sram_view.idx][8*b +: 8] <= req_q.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            rvalid_o <= 1'b0;
            err_o    <= 1'b0;
        end
        else
        begin
            rvalid_o <= pop;
            err_o    <= pop & resp_err;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (pop)
        begin
            rdata_o <= resp_data;
        end
    end

endmodule

//--- src/mem_subsys_top.sv
`timescale 1ns/10ps

module mem_subsys_top #(
    parameter int QUEUE_DEPTH   = 2,
    parameter int HEARTBEAT_DIV = 100_000_000
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       req_i,
    input  logic [mem_pkg::ADDR_W-1:0] addr_i,
    input  logic                       we_i,
    input  logic [mem_pkg::BE_W-1:0]   be_i,
    input  logic [mem_pkg::DATA_W-1:0] wdata_i,
    output logic                       gnt_o,
    output logic                       rvalid_o,
    output logic [mem_pkg::DATA_W-1:0] rdata_o,
    output logic                       err_o,
    output logic                       clk_led_o
);

    mem_req_if front_q ();
    mem_req_if q_back ();

    bus_front i_bus_front (
        .req_i   ( req_i   ),
        .addr_i  ( addr_i  ),
        .we_i    ( we_i    ),
        .be_i    ( be_i    ),
        .wdata_i ( wdata_i ),
        .gnt_o   ( gnt_o   ),
        .front_q ( front_q )
    );

    req_fifo #(
        .DEPTH ( QUEUE_DEPTH )
    ) i_req_fifo (
        .clk_i  ( clk_i   ),
        .rst_ni ( rst_ni  ),
        .in_q   ( front_q ),
        .out_q  ( q_back  )
    );

    mem_backend i_mem_backend (
        .clk_i    ( clk_i    ),
        .rst_ni   ( rst_ni   ),
        .req_q    ( q_back   ),
        .rvalid_o ( rvalid_o ),
        .rdata_o  ( rdata_o  ),
        .err_o    ( err_o    )
    );

    heartbeat #(
        .DIV ( HEARTBEAT_DIV )
    ) i_heartbeat (
        .clk_i  ( clk_i     ),
        .rst_ni ( rst_ni    ),
        .led_o  ( clk_led_o )
    );

endmodule

//--- dv/tb_mem_subsys.sv
`timescale 1ns/10ps

module tb_mem_subsys;

    localparam int QUEUE_DEPTH = 2;
    localparam int HB_DIV      = 8;
    localparam int HB_EDGES    = 4 * HB_DIV;
    localparam int DRAIN_LIMIT = 10;

    typedef struct packed {
        logic        we;
        logic        b2b;
        logic [31:0] addr;
        logic [3:0]  be;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic        err;
    } vector_t;

    logic        clk_i;
    logic        rst_ni;
    logic        req_i;
    logic [31:0] addr_i;
    logic        we_i;
    logic [3:0]  be_i;
    logic [31:0] wdata_i;
    logic        gnt_o;
    logic        rvalid_o;
    logic [31:0] rdata_o;
    logic        err_o;
    logic        clk_led_o;

    vector_t     vecs [$];
    vector_t     exp_q [$];
    vector_t     resp_exp;
    logic [31:0] lfsr;
    int          cycle_cnt;
    int          cycle_limit;
    int          granted_cnt;
    int          resp_cnt;
    int          max_inflight;

    mem_subsys_top #(
        .QUEUE_DEPTH   ( QUEUE_DEPTH ),
        .HEARTBEAT_DIV ( HB_DIV      )
    ) dut (
        .clk_i     ( clk_i     ),
        .rst_ni    ( rst_ni    ),
        .req_i     ( req_i     ),
        .addr_i    ( addr_i    ),
        .we_i      ( we_i      ),
        .be_i      ( be_i      ),
        .wdata_i   ( wdata_i   ),
        .gnt_o     ( gnt_o     ),
        .rvalid_o  ( rvalid_o  ),
        .rdata_o   ( rdata_o   ),
        .err_o     ( err_o     ),
        .clk_led_o ( clk_led_o )
    );

    always #2 clk_i = ~clk_i;

    task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("Test failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task pick_gap(output int gap);
        int b;
        gap = 0;
        for (b = 0; b < 2; b++)
        begin
            lfsr = lfsr_next(lfsr);
            gap  = gap | (int'(lfsr[0]) << b);
        end
    endtask

    task load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] op_s;
        logic [31:0] addr;
        logic [31:0] be;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [31:0] err;
        vector_t     v;
        fd = $fopen("dv/mem_golden.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file dv/mem_golden.txt");
            $display("Test failed");
            $fatal(1, "stimulus file missing");
        end
        while (!$feof(fd))
        begin
            n = $fgets(line, fd);
            if (n > 0)
            begin
                // Comment and blank lines do not yield six fields
                if ($sscanf(line, "%s %h %h %h %h %h", op_s, addr, be, wdata, rdata, err) == 6)
                begin
                    if (op_s != "rd" && op_s != "wr" && op_s != "rd0" && op_s != "wr0")
                    begin
                        $display("Unknown operation in the stimulus file: %s", line);
                        $display("Test failed");
                        $fatal(1, "bad stimulus line");
                    end
                    v.we    = (op_s == "wr" || op_s == "wr0");
                    v.b2b   = (op_s == "rd0" || op_s == "wr0");
                    v.addr  = addr;
                    v.be    = be[3:0];
                    v.wdata = wdata;
                    v.rdata = rdata;
                    v.err   = err[0];
                    vecs.push_back(v);
                end
            end
        end
        $fclose(fd);
    endtask

    // Holds each request until it is granted, then queues the expected response
    task drive_requests();
        int   i;
        int   gap;
        logic granted;
        for (i = 0; i < vecs.size(); i++)
        begin
            gap = 0;
            if (!vecs[i].b2b)
            begin
                pick_gap(gap);
            end
            if (gap > 0)
            begin
                req_i = 1'b0;
                repeat (gap) @(negedge clk_i);
            end
            req_i   = 1'b1;
            addr_i  = vecs[i].addr;
            we_i    = vecs[i].we;
            be_i    = vecs[i].be;
            wdata_i = vecs[i].wdata;
            granted = 1'b0;
            while (!granted)
            begin
                #1;
                // Queue holds the granted requests whose response has not risen yet
                check_value("gnt_o", 32'(gnt_o),
                            32'((granted_cnt - resp_cnt) < QUEUE_DEPTH));
                granted = gnt_o;
                @(posedge clk_i);
                if (granted)
                begin
                    exp_q.push_back(vecs[i]);
                    granted_cnt++;
                end
                @(negedge clk_i);
            end
        end
        req_i = 1'b0;
    endtask

    task check_heartbeat();
        int edges;
        check_value("clk_led_o", 32'(clk_led_o), 32'd0);
        for (edges = 1; edges <= HB_EDGES; edges++)
        begin
            @(posedge clk_i);
            @(negedge clk_i);
            check_value("clk_led_o", 32'(clk_led_o), 32'((edges / HB_DIV) % 2));
        end
    endtask

    always @(negedge clk_i)
    begin
        if (rst_ni && rvalid_o)
        begin
            if (exp_q.size() == 0)
            begin
                $display("A response arrived with no request outstanding");
                $display("Test failed");
                $fatal(1, "unexpected response");
            end
            else
            begin
                if (granted_cnt - resp_cnt > max_inflight)
                begin
                    max_inflight = granted_cnt - resp_cnt;
                end
                resp_exp = exp_q.pop_front();
                resp_cnt++;
                check_value("rdata_o", rdata_o, resp_exp.rdata);
                check_value("err_o", 32'(err_o), 32'(resp_exp.err));
            end
        end
    end

    always @(posedge clk_i)
    begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit)
        begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    initial
    begin
        int drain;
        clk_i        = 1'b0;
        rst_ni       = 1'b0;
        req_i        = 1'b0;
        addr_i       = '0;
        we_i         = 1'b0;
        be_i         = '0;
        wdata_i      = '0;
        lfsr         = 32'he9a0_48ce;
        cycle_cnt    = 0;
        cycle_limit  = 0;
        granted_cnt  = 0;
        resp_cnt     = 0;
        max_inflight = 0;
        load_vectors();
        cycle_limit = vecs.size() * 8 + HB_EDGES + 50;
        repeat (3) @(negedge clk_i);
        rst_ni = 1'b1;
        check_value("rvalid_o", 32'(rvalid_o), 32'd0);
        check_value("err_o", 32'(err_o), 32'd0);
        check_value("gnt_o", 32'(gnt_o), 32'(req_i));
        fork
            drive_requests();
            check_heartbeat();
        join
        drain = 0;
        while (exp_q.size() != 0 && drain < DRAIN_LIMIT)
        begin
            @(posedge clk_i);
            drain++;
        end
        if (exp_q.size() != 0)
        begin
            $display("%0d responses never arrived", exp_q.size());
            $display("Test failed");
            $fatal(1, "missing responses");
        end
        else if (max_inflight < 2)
        begin
            $display("Back-to-back requests never overlapped in the pipeline");
            $display("Test failed");
            $fatal(1, "no overlap seen");
        end
        else
        begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

//--- mem_backend/boot_rom.hex
3c0a0001
8d4b0010
a5f00f5a
12345678
deadbeef
0badc0de
cafef00d
00000013
ffffffff
55aa55aa
c001d00d
76543210
0f1e2d3c
4b5a6978
feedface
80000000

//--- dv/mem_golden.txt
# op: rd/wr wait 0 to 3 idle cycles first, rd0/wr0 follow the previous request directly
# columns: op addr be wdata exp_rdata exp_err (all hex)
rd 00010000 f 00000000 3c0a0001 0
rd 00010004 f 00000000 8d4b0010 0
rd 0001000c f 00000000 12345678 0
rd 00010020 f 00000000 ffffffff 0
rd 0001003c f 00000000 80000000 0
rd 00010040 f 00000000 3c0a0001 0
rd 00010044 f 00000000 8d4b0010 0
rd 0001fffc f 00000000 80000000 0
wr 80000000 f 11223344 00000000 0
rd 80000000 f 00000000 11223344 0
wr 80000010 f a5a5a5a5 00000000 0
wr 80000010 3 1234beef 00000000 0
rd 80000010 f 00000000 a5a5beef 0
wr 80000010 4 00770000 00000000 0
rd 80000010 f 00000000 a577beef 0
wr 80000014 8 ab000000 00000000 0
rd 80000014 f 00000000 ab000000 0
rd 80001000 f 00000000 11223344 0
rd 80001010 f 00000000 a577beef 0
wr 80002ffc f cafe0001 00000000 0
rd 80000ffc f 00000000 cafe0001 0
wr 80000000 0 ffffffff 00000000 0
rd 80000000 f 00000000 11223344 0
wr 00010008 f deadbeef 00000000 1
rd 00000000 f 00000000 00000000 1
wr 40000000 f 12345678 00000000 1
rd 40000000 f 00000000 00000000 1
rd 0000fffc f 00000000 00000000 1
rd 00020000 f 00000000 00000000 1
rd 90000000 f 00000000 00000000 1
rd 00010008 f 00000000 a5f00f5a 0
rd 80000000 f 00000000 11223344 0
wr 80000020 f 01010101 00000000 0
wr0 80000024 f 02020202 00000000 0
rd0 80000020 f 00000000 01010101 0
rd0 80000024 f 00000000 02020202 0
rd0 00010010 f 00000000 deadbeef 0
rd0 00000004 f 00000000 00000000 1
rd0 80000014 f 00000000 ab000000 0
rd0 0001001c f 00000000 00000013 0

//--- all.f
common/mem_pkg.sv
common/mem_req_if.sv
src/bus_front.sv
src/req_fifo.sv
src/heartbeat.sv
mem_backend/mem_backend.sv
src/mem_subsys_top.sv
dv/tb_mem_subsys.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_mem_subsys
RTL_TOP    := mem_subsys_top
FILELIST   := all.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a non-zero exit status
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
